//--- source/sa_pkg.sv
// Shared sizes and bundle types for the 2x2 integer systolic array
// Activations and weights are signed two's complement
// Sums wrap at ACC_W bits, there is no saturation
package sa_pkg;

    // ------------------------------------------------------------
    // Grid size
    // ------------------------------------------------------------
    localparam int ROWS = 2;
    localparam int COLS = 2;

    // ------------------------------------------------------------
    // Datapath widths
    // ------------------------------------------------------------
    // Signed operands
    localparam int A_W   = 8;
    localparam int B_W   = 8;
    // Full product of A_W x B_W
    localparam int P_W   = 16;
    // Accumulator and result chain
    localparam int ACC_W = 24;
    // Number of low bits that may be ignored by zero detection
    localparam int TH_W  = 2;

    // ------------------------------------------------------------
    // Pipeline depth
    // ------------------------------------------------------------
    localparam int MUL_STAGES = 2;
    // Gate reg + multiplier stages + intermediate reg
    localparam int PE_LATENCY = MUL_STAGES + 2;

    // One activation and one weight, moving together into a PE
    typedef struct packed {
        logic signed [A_W-1:0] a;
        logic signed [B_W-1:0] b;
    } operand_t;

    // Array-wide controls, broadcast to every PE
    typedef struct packed {
        // Synchronous clear of all PE state
        logic reg_clear;
        // Global stall when low
        logic pipeline_en;
        // Shift the result chain one row down
        logic cscan_en;
        // Shift the cell-enable chain one PE along
        logic cell_sc_en;
    } pe_ctrl_t;

endpackage

//--- source/sa_stage_reg.sv
// Delay line of DEPTH registers for any packed payload
// DEPTH must be at least 1; all stages advance together on i_en
`timescale 1ns/1ns

module sa_stage_reg #(
    parameter type T     = logic,
    parameter int  DEPTH = 1
) (
    input  logic i_clk,
    input  logic i_rstn,
    input  logic i_clear,
    input  logic i_en,
    input  T     i_d,
    output T     o_q
);

    // Stage 0 is the newest value
    T stage_q [DEPTH];

    always_ff @(posedge i_clk or negedge i_rstn) begin
        if (!i_rstn) begin
            for (int i = 0; i < DEPTH; i++) begin
                stage_q[i] <= '0;
            end
        end else if (i_clear) begin
            for (int i = 0; i < DEPTH; i++) begin
                stage_q[i] <= '0;
            end
        end else if (i_en) begin
            stage_q[0] <= i_d;
            // Shift older values one step on
            for (int i = 1; i < DEPTH; i++) begin
                stage_q[i] <= stage_q[i-1];
            end
        end
    end

    assign o_q = stage_q[DEPTH-1];

endmodule

//--- source/sa_operand_gate.sv
// Zero detection with a bit-negligence threshold, plus the operand registers
// A negative operand is never negligible, since its top bit is set
// On a negligible pair the operand registers keep their old value
`timescale 1ns/1ns

module sa_operand_gate (
    input  logic                      i_clk,
    input  logic                      i_rstn,
    input  logic                      i_clear,
    input  logic                      i_en,
    input  sa_pkg::operand_t          i_op,
    input  logic [sa_pkg::TH_W-1:0]   i_thres,
    output sa_pkg::operand_t          o_op,
    output logic                      o_zero
);

    logic             a_neg;
    logic             b_neg;
    logic             zero_d;
    logic             zero_q;
    sa_pkg::operand_t op_q;

    // ------------------------------------------------------------
    // Negligence detection
    // ------------------------------------------------------------
    // Drop the i_thres lowest bits, the rest must be all zero
    assign a_neg  = (($unsigned(i_op.a) >> i_thres) == '0);
    assign b_neg  = (($unsigned(i_op.b) >> i_thres) == '0);

    // Either side negligible makes the whole product negligible
    assign zero_d = a_neg | b_neg;

    // ------------------------------------------------------------
    // Flag register, follows the pipeline like any operand
    // ------------------------------------------------------------
    always_ff @(posedge i_clk or negedge i_rstn) begin
        if (!i_rstn) begin
            zero_q <= 1'b0;
        end else if (i_clear) begin
            zero_q <= 1'b0;
        end else if (i_en) begin
            zero_q <= zero_d;
        end
    end

    // ------------------------------------------------------------
    // Operand registers feeding the multiplier
    // ------------------------------------------------------------
    // Frozen on negligible pairs so the multiplier does not toggle
    always_ff @(posedge i_clk or negedge i_rstn) begin
        if (!i_rstn) begin
            op_q <= '0;
        end else if (i_clear) begin
            op_q <= '0;
        end else if (i_en && !zero_d) begin
            op_q <= i_op;
        end
    end

    assign o_op   = op_q;
    assign o_zero = zero_q;

endmodule

//--- source/sa_multiplier.sv
// Signed integer multiplier, output retimed through MUL_STAGES registers
// The product is valid MUL_STAGES enabled cycles after the operands
// Full-width product, no truncation
`timescale 1ns/1ns

module sa_multiplier (
    input  logic                            i_clk,
    input  logic                            i_rstn,
    input  logic                            i_clear,
    input  logic                            i_en,
    input  sa_pkg::operand_t                i_op,
    output logic signed [sa_pkg::P_W-1:0]   o_prod
);

    logic signed [sa_pkg::P_W-1:0] prod_d;
    logic signed [sa_pkg::P_W-1:0] prod_q [sa_pkg::MUL_STAGES];

    // Both struct members are signed, so this is a signed multiply
    assign prod_d = i_op.a * i_op.b;

    // ------------------------------------------------------------
    // Retiming registers
    // ------------------------------------------------------------
    // Synthesis may push these back into the partial-product tree
    always_ff @(posedge i_clk or negedge i_rstn) begin
        if (!i_rstn) begin
            for (int i = 0; i < sa_pkg::MUL_STAGES; i++) begin
                prod_q[i] <= '0;
            end
        end else if (i_clear) begin
            for (int i = 0; i < sa_pkg::MUL_STAGES; i++) begin
                prod_q[i] <= '0;
            end
        end else if (i_en) begin
            prod_q[0] <= prod_d;
            for (int i = 1; i < sa_pkg::MUL_STAGES; i++) begin
                prod_q[i] <= prod_q[i-1];
            end
        end
    end

    assign o_prod = prod_q[sa_pkg::MUL_STAGES-1];

endmodule

//--- source/sa_accumulator.sv
// Adder, hold register, local accumulator and scan register of one PE
// i_zero and i_cswitch must be aligned with the intermediate product
// Scanning works whenever i_scan_en is high, even in a disabled cell
`timescale 1ns/1ns

module sa_accumulator (
    input  logic                           i_clk,
    input  logic                           i_rstn,
    input  logic                           i_clear,
    input  logic                           i_en,
    input  logic                           i_scan_en,
    input  logic signed [sa_pkg::P_W-1:0]  i_prod,
    input  logic                           i_zero,
    input  logic                           i_cswitch,
    input  logic [sa_pkg::ACC_W-1:0]       i_chain,
    output logic [sa_pkg::ACC_W-1:0]       o_chain
);

    // Intermediate stage between multiplier and adder
    logic signed [sa_pkg::P_W-1:0]  mul_q;
    logic signed [sa_pkg::P_W-1:0]  mul_gated;

    logic [sa_pkg::ACC_W-1:0]       acc_q;
    logic [sa_pkg::ACC_W-1:0]       sc_q;
    logic [sa_pkg::ACC_W-1:0]       hold_q;
    logic [sa_pkg::ACC_W-1:0]       acc_src;
    logic [sa_pkg::ACC_W-1:0]       add_op;
    logic [sa_pkg::ACC_W-1:0]       acc_sum;
    logic [sa_pkg::ACC_W-1:0]       sc_d;
    logic                           acc_en;
    logic                           sc_en;

    // ------------------------------------------------------------
    // Intermediate product register
    // ------------------------------------------------------------
    always_ff @(posedge i_clk or negedge i_rstn) begin
        if (!i_rstn) begin
            mul_q <= '0;
        end else if (i_clear) begin
            mul_q <= '0;
        end else if (i_en) begin
            mul_q <= i_prod;
        end
    end

    // A negligible pair on a context switch cannot be skipped,
    // its stale product is forced to zero instead
    assign mul_gated = (i_zero && i_cswitch) ? '0 : mul_q;

    // ------------------------------------------------------------
    // Adder operand selection
    // ------------------------------------------------------------
    // Context switch starts the new sum from the scanned-in value
    assign acc_src = i_cswitch ? sc_q : acc_q;

    // Negligible cycle replays the last operand, adder stays still
    assign add_op  = (i_zero && !i_cswitch) ? hold_q : acc_src;

    assign acc_sum = add_op
                   + {{(sa_pkg::ACC_W-sa_pkg::P_W){mul_gated[sa_pkg::P_W-1]}}, mul_gated};

    // Hold register, loads every cycle
    always_ff @(posedge i_clk or negedge i_rstn) begin
        if (!i_rstn) begin
            hold_q <= '0;
        end else if (i_clear) begin
            hold_q <= '0;
        end else begin
            hold_q <= add_op;
        end
    end

    // ------------------------------------------------------------
    // Local accumulator
    // ------------------------------------------------------------
    // Skips negligible cycles unless a context switch is due
    assign acc_en = i_en & (i_cswitch | ~i_zero);

    always_ff @(posedge i_clk or negedge i_rstn) begin
        if (!i_rstn) begin
            acc_q <= '0;
        end else if (i_clear) begin
            acc_q <= '0;
        end else if (acc_en) begin
            acc_q <= acc_sum;
        end
    end

    // ------------------------------------------------------------
    // Scan register and context switch
    // ------------------------------------------------------------
    assign sc_en = i_scan_en | (i_cswitch & i_en);

    // Old sum parks here on a switch, otherwise take the row above
    assign sc_d  = i_cswitch ? acc_q : i_chain;

    always_ff @(posedge i_clk or negedge i_rstn) begin
        if (!i_rstn) begin
            sc_q <= '0;
        end else if (i_clear) begin
            sc_q <= '0;
        end else if (sc_en) begin
            sc_q <= sc_d;
        end
    end

    assign o_chain = sc_q;

endmodule

//--- source/sa_pe.sv
// One multiply-accumulate processing element of the systolic array
// Pipeline registers advance only when pipeline_en and i_cell_en are both high
// i_cswitch must arrive PE_LATENCY enabled cycles after the last pair it closes
`timescale 1ns/1ns

module sa_pe (
    input  logic                        i_clk,
    input  logic                        i_rstn,
    input  sa_pkg::pe_ctrl_t            i_ctrl,
    input  sa_pkg::operand_t            i_op,
    input  logic [sa_pkg::ACC_W-1:0]    i_c,
    input  logic                        i_cell_en,
    input  logic                        i_cswitch,
    input  logic [sa_pkg::TH_W-1:0]     i_thres,
    output sa_pkg::operand_t            o_op,
    output logic [sa_pkg::ACC_W-1:0]    o_c,
    output logic                        o_cell_en,
    output logic                        o_cswitch
);

    // ------------------------------------------------------------
    // Control
    // ------------------------------------------------------------
    logic                           pe_en;
    logic                           scan_en;
    logic                           cell_en_q;

    // Datapath chain
    sa_pkg::operand_t               gated_op;
    logic                           zero_gate;
    logic                           zero_add;
    logic signed [sa_pkg::P_W-1:0]  prod;

    // Element enable, stalls the whole local pipeline
    assign pe_en   = i_cell_en & i_ctrl.pipeline_en;

    // Result chain shifts regardless of the cell enable
    assign scan_en = i_ctrl.cscan_en & i_ctrl.pipeline_en;

    // ------------------------------------------------------------
    // Propagation registers
    // ------------------------------------------------------------
    // Activation goes right, weight goes down, both in one struct
    sa_stage_reg #(
        .T     (sa_pkg::operand_t),
        .DEPTH (1)
    ) u_prop_op (
        .i_clk   (i_clk),
        .i_rstn  (i_rstn),
        .i_clear (i_ctrl.reg_clear),
        .i_en    (pe_en),
        .i_d     (i_op),
        .o_q     (o_op)
    );

    // Context switch follows the activation skew along the row
    sa_stage_reg #(
        .T     (logic),
        .DEPTH (1)
    ) u_prop_cs (
        .i_clk   (i_clk),
        .i_rstn  (i_rstn),
        .i_clear (i_ctrl.reg_clear),
        .i_en    (pe_en),
        .i_d     (i_cswitch),
        .o_q     (o_cswitch)
    );

    // ------------------------------------------------------------
    // Datapath: gate, multiplier, accumulator
    // ------------------------------------------------------------
    sa_operand_gate u_gate (
        .i_clk   (i_clk),
        .i_rstn  (i_rstn),
        .i_clear (i_ctrl.reg_clear),
        .i_en    (pe_en),
        .i_op    (i_op),
        .i_thres (i_thres),
        .o_op    (gated_op),
        .o_zero  (zero_gate)
    );

    sa_multiplier u_mul (
        .i_clk   (i_clk),
        .i_rstn  (i_rstn),
        .i_clear (i_ctrl.reg_clear),
        .i_en    (pe_en),
        .i_op    (gated_op),
        .o_prod  (prod)
    );

    // Zero flag shim, multiplier stages plus the intermediate register
    sa_stage_reg #(
        .T     (logic),
        .DEPTH (sa_pkg::MUL_STAGES + 1)
    ) u_zero_shim (
        .i_clk   (i_clk),
        .i_rstn  (i_rstn),
        .i_clear (i_ctrl.reg_clear),
        .i_en    (pe_en),
        .i_d     (zero_gate),
        .o_q     (zero_add)
    );

    sa_accumulator u_acc (
        .i_clk     (i_clk),
        .i_rstn    (i_rstn),
        .i_clear   (i_ctrl.reg_clear),
        .i_en      (pe_en),
        .i_scan_en (scan_en),
        .i_prod    (prod),
        .i_zero    (zero_add),
        .i_cswitch (i_cswitch),
        .i_chain   (i_c),
        .o_chain   (o_c)
    );

    // ------------------------------------------------------------
    // Cell-enable scan chain
    // ------------------------------------------------------------
    always_ff @(posedge i_clk or negedge i_rstn) begin
        if (!i_rstn) begin
            cell_en_q <= 1'b0;
        end else if (i_ctrl.reg_clear) begin
            cell_en_q <= 1'b0;
        end else if (i_ctrl.cell_sc_en) begin
            cell_en_q <= i_cell_en;
        end
    end

    assign o_cell_en = cell_en_q;

endmodule

//--- source/sa_array.sv
// Top level: ROWS x COLS grid of sa_pe elements
// Row r activations and column c weights must be skewed by r and c cycles
// Results leave at the bottom, lowest row first
`timescale 1ns/1ns

module sa_array (
    input  logic                                          i_clk,
    input  logic                                          i_rstn,
    input  sa_pkg::pe_ctrl_t                              i_ctrl,
    input  logic [sa_pkg::ROWS-1:0][sa_pkg::A_W-1:0]      i_a,
    input  logic [sa_pkg::COLS-1:0][sa_pkg::B_W-1:0]      i_b,
    input  logic [sa_pkg::COLS-1:0][sa_pkg::ACC_W-1:0]    i_c,
    input  logic [sa_pkg::ROWS-1:0]                       i_cswitch,
    input  logic                                          i_cell_en,
    input  logic [sa_pkg::TH_W-1:0]                       i_thres,
    output logic [sa_pkg::COLS-1:0][sa_pkg::ACC_W-1:0]    o_c,
    output logic                                          o_cell_en
);

    localparam int N_PE = sa_pkg::ROWS * sa_pkg::COLS;

    // Outputs of every PE
    sa_pkg::operand_t         op_out [sa_pkg::ROWS][sa_pkg::COLS];
    logic [sa_pkg::ACC_W-1:0] c_out  [sa_pkg::ROWS][sa_pkg::COLS];
    logic                     cs_out [sa_pkg::ROWS][sa_pkg::COLS];

    // Cell-enable chain, flat in row-major order
    logic                     ce_link [N_PE+1];

    assign ce_link[0] = i_cell_en;
    assign o_cell_en  = ce_link[N_PE];

    for (genvar r = 0; r < sa_pkg::ROWS; r++) begin : g_row
        for (genvar c = 0; c < sa_pkg::COLS; c++) begin : g_col
            sa_pkg::operand_t         op_in;
            logic [sa_pkg::ACC_W-1:0] c_in;
            logic                     cs_in;

            // Left edge takes ports, inner columns take the left neighbour
            if (c == 0) begin : g_left
                assign op_in.a = i_a[r];
                assign cs_in   = i_cswitch[r];
            end else begin : g_inner_col
                assign op_in.a = op_out[r][c-1].a;
                assign cs_in   = cs_out[r][c-1];
            end

            // Top edge takes ports, inner rows take the PE above
            if (r == 0) begin : g_top
                assign op_in.b = i_b[c];
                assign c_in    = i_c[c];
            end else begin : g_inner_row
                assign op_in.b = op_out[r-1][c].b;
                assign c_in    = c_out[r-1][c];
            end

            sa_pe u_pe (
                .i_clk     (i_clk),
                .i_rstn    (i_rstn),
                .i_ctrl    (i_ctrl),
                .i_op      (op_in),
                .i_c       (c_in),
                .i_cell_en (ce_link[r*sa_pkg::COLS + c]),
                .i_cswitch (cs_in),
                .i_thres   (i_thres),
                .o_op      (op_out[r][c]),
                .o_c       (c_out[r][c]),
                .o_cell_en (ce_link[r*sa_pkg::COLS + c + 1]),
                .o_cswitch (cs_out[r][c])
            );
        end

        // Bottom row drives the result ports
        if (r == sa_pkg::ROWS - 1) begin : g_bottom
            for (genvar c = 0; c < sa_pkg::COLS; c++) begin : g_out
                assign o_c[c] = c_out[r][c];
            end
        end
    end

endmodule

//--- tests/sa_tb.sv
// Self-checking testbench for sa_array, run from the project root
// Reads 22 hex words per test from tests/sa_vectors.txt
// Streams are fixed at K = 4 pairs per row and per column
`timescale 1ns/1ns

module sa_tb;

    // ------------------------------------------------------------
    // Vector file layout and run limits
    // ------------------------------------------------------------
    localparam int K         = 4;
    localparam int N_REC     = 3;
    localparam int OFF_A     = 2;
    localparam int OFF_B     = OFF_A + sa_pkg::ROWS * K;
    localparam int OFF_EXP   = OFF_B + sa_pkg::COLS * K;
    localparam int REC_WORDS = OFF_EXP + sa_pkg::ROWS * sa_pkg::COLS;
    // Enabled steps until the bottom-right PE has switched context
    localparam int N_STEPS   = K + sa_pkg::ROWS + sa_pkg::COLS + sa_pkg::PE_LATENCY - 1;
    localparam int N_PE      = sa_pkg::ROWS * sa_pkg::COLS;
    localparam int SHIFT_MAX = 8;
    localparam int CLK_HALF  = 2;
    localparam int RST_CYC   = 10;
    localparam int DRV_DLY   = 1;

    logic                                          i_clk;
    logic                                          i_rstn;
    sa_pkg::pe_ctrl_t                              ctrl;
    logic [sa_pkg::ROWS-1:0][sa_pkg::A_W-1:0]      a_in;
    logic [sa_pkg::COLS-1:0][sa_pkg::B_W-1:0]      b_in;
    logic [sa_pkg::COLS-1:0][sa_pkg::ACC_W-1:0]    c_in;
    logic [sa_pkg::ROWS-1:0]                       cswitch;
    logic                                          cell_en;
    logic [sa_pkg::TH_W-1:0]                       thres;
    logic [sa_pkg::COLS-1:0][sa_pkg::ACC_W-1:0]    c_out;
    logic                                          cell_en_out;

    logic [sa_pkg::ACC_W-1:0] vec_mem [N_REC*REC_WORDS];
    logic [31:0]              rng_state;
    int                       errors;
    int                       checks;
    int                       tests_run;
    int                       tests_bad;
    int                       test_err_base;

    sa_array dut_i (
        .i_clk     (i_clk),
        .i_rstn    (i_rstn),
        .i_ctrl    (ctrl),
        .i_a       (a_in),
        .i_b       (b_in),
        .i_c       (c_in),
        .i_cswitch (cswitch),
        .i_cell_en (cell_en),
        .i_thres   (thres),
        .o_c       (c_out),
        .o_cell_en (cell_en_out)
    );

    // 4 ns clock
    initial begin
        i_clk = 1'b0;
        forever begin
            #CLK_HALF i_clk = ~i_clk;
        end
    end

    // ------------------------------------------------------------
    // Vector access and reference model
    // ------------------------------------------------------------
    function automatic logic [sa_pkg::TH_W-1:0] thres_of(input int rec);
        return vec_mem[rec*REC_WORDS][sa_pkg::TH_W-1:0];
    endfunction

    function automatic logic stall_of(input int rec);
        return vec_mem[rec*REC_WORDS + 1][0];
    endfunction

    function automatic logic [sa_pkg::A_W-1:0] a_of(input int rec, input int r, input int k);
        return vec_mem[rec*REC_WORDS + OFF_A + r*K + k][sa_pkg::A_W-1:0];
    endfunction

    function automatic logic [sa_pkg::B_W-1:0] b_of(input int rec, input int c, input int k);
        return vec_mem[rec*REC_WORDS + OFF_B + c*K + k][sa_pkg::B_W-1:0];
    endfunction

    function automatic logic [sa_pkg::ACC_W-1:0] exp_of(input int rec, input int r, input int c);
        return vec_mem[rec*REC_WORDS + OFF_EXP + r*sa_pkg::COLS + c];
    endfunction

    // Negligible when nothing is left above the low th bits
    function automatic logic is_negligible(input logic [7:0] v, input int th);
        return (v >> th) == 8'd0;
    endfunction

    function automatic logic [sa_pkg::ACC_W-1:0] model_dot(input int rec, input int r,
                                                           input int c);
        logic [sa_pkg::ACC_W-1:0]        sum;
        logic signed [sa_pkg::ACC_W-1:0] prod;
        logic signed [sa_pkg::A_W-1:0]   av;
        logic signed [sa_pkg::B_W-1:0]   bv;
        int                              th;
        int                              k;
        sum = '0;
        th  = int'(thres_of(rec));
        for (k = 0; k < K; k++) begin
            av = a_of(rec, r, k);
            bv = b_of(rec, c, k);
            // Either side negligible drops the whole product
            if (!is_negligible(av, th) && !is_negligible(bv, th)) begin
                prod = av * bv;
                sum  = sum + prod;
            end
        end
        return sum;
    endfunction

    function automatic logic [31:0] next_rand(input logic [31:0] x);
        logic [31:0] y;
        y = x;
        y = y ^ (y << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // ------------------------------------------------------------
    // Stimulus and checking tasks
    // ------------------------------------------------------------
    task automatic next_cycle();
        @(posedge i_clk);
        #DRV_DLY;
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error: %s expected 0x%0h got 0x%0h", name, exp, got);
        end
    endtask

    task automatic end_test(input string name);
        int n;
        n = errors - test_err_base;
        tests_run++;
        if (n != 0) begin
            tests_bad++;
        end
        $display("Test %s: %s, %0d mismatches", name, (n == 0) ? "PASS" : "FAIL", n);
        test_err_base = errors;
    endtask

    // File expectations must follow the zero rule too
    task automatic check_vectors(input int rec);
        int r;
        int c;
        for (r = 0; r < sa_pkg::ROWS; r++) begin
            for (c = 0; c < sa_pkg::COLS; c++) begin
                check_value($sformatf("vector_exp[%0d][%0d]", r, c),
                            32'(exp_of(rec, r, c)), 32'(model_dot(rec, r, c)));
            end
        end
    endtask

    // Clear all PEs, then fill the cell-enable chain with ones
    task automatic clear_and_enable();
        int i;
        ctrl           = '0;
        ctrl.reg_clear = 1'b1;
        next_cycle();
        ctrl.reg_clear  = 1'b0;
        cell_en         = 1'b1;
        ctrl.cell_sc_en = 1'b1;
        for (i = 0; i < N_PE; i++) begin
            next_cycle();
        end
        ctrl.cell_sc_en = 1'b0;
        check_value("o_cell_en", 32'(cell_en_out), 32'd1);
    endtask

    // One enabled edge per step with random stall cycles in front
    task automatic stream_record(input int rec, output int stalls);
        int s;
        int r;
        int c;
        int k;
        int len;
        thres  = thres_of(rec);
        stalls = 0;
        for (s = 0; s < N_STEPS; s++) begin
            // Row r runs r steps late
            for (r = 0; r < sa_pkg::ROWS; r++) begin
                k = s - r;
                if (k >= 0 && k < K) begin
                    a_in[r] = a_of(rec, r, k);
                end else begin
                    a_in[r] = '0;
                end
                // Switch rides with the empty slot after the last pair
                cswitch[r] = (s == K + r + sa_pkg::PE_LATENCY);
            end
            // Column c runs c steps late
            for (c = 0; c < sa_pkg::COLS; c++) begin
                k = s - c;
                if (k >= 0 && k < K) begin
                    b_in[c] = b_of(rec, c, k);
                end else begin
                    b_in[c] = '0;
                end
            end
            len = 0;
            if (stall_of(rec)) begin
                rng_state = next_rand(rng_state);
                if (rng_state[0] == 1'b0) begin
                    len = 1 + int'(rng_state[2:1]);
                end
            end
            if (len > 0) begin
                ctrl.pipeline_en = 1'b0;
                for (k = 0; k < len; k++) begin
                    next_cycle();
                end
            end
            stalls           = stalls + len;
            ctrl.pipeline_en = 1'b1;
            next_cycle();
        end
    endtask

    // Second switch with no new pairs parks the restarted sum
    task automatic switch_empty();
        int s;
        int r;
        a_in             = '0;
        b_in             = '0;
        ctrl.pipeline_en = 1'b1;
        for (s = 0; s < sa_pkg::ROWS + sa_pkg::COLS; s++) begin
            for (r = 0; r < sa_pkg::ROWS; r++) begin
                cswitch[r] = (s == r);
            end
            next_cycle();
        end
        cswitch = '0;
    endtask

    // Bottom row first, then one shift per row above
    task automatic scan_and_check(input int rec, input logic expect_zero);
        int r;
        int c;
        for (r = sa_pkg::ROWS - 1; r >= 0; r--) begin
            if (r != sa_pkg::ROWS - 1) begin
                ctrl.pipeline_en = 1'b1;
                ctrl.cscan_en    = 1'b1;
                next_cycle();
                ctrl.cscan_en = 1'b0;
            end
            for (c = 0; c < sa_pkg::COLS; c++) begin
                check_value($sformatf("o_c[%0d] row %0d", c, r), 32'(c_out[c]),
                            expect_zero ? 32'd0 : 32'(exp_of(rec, r, c)));
            end
        end
    endtask

    task automatic run_dot_test(input string name, input int rec);
        int stalls;
        check_vectors(rec);
        clear_and_enable();
        stream_record(rec, stalls);
        if (stall_of(rec) && stalls == 0) begin
            errors++;
            $display("No stall cycles were inserted in test %s", name);
        end
        scan_and_check(rec, 1'b0);
        // New context started from a cleared scan register plus a forced zero
        switch_empty();
        scan_and_check(rec, 1'b1);
        end_test(name);
    endtask

    // A single one goes in and zeros follow it
    task automatic check_cell_chain();
        int shifts;
        int i;
        cell_en         = 1'b1;
        ctrl.cell_sc_en = 1'b1;
        next_cycle();
        cell_en = 1'b0;
        shifts  = 1;
        while (cell_en_out !== 1'b1 && shifts < SHIFT_MAX) begin
            next_cycle();
            shifts++;
        end
        if (cell_en_out !== 1'b1) begin
            errors++;
            $display("o_cell_en did not rise within %0d shifts", SHIFT_MAX);
        end else begin
            check_value("cell_en_shifts", 32'(shifts), 32'(N_PE));
        end
        for (i = 0; i < N_PE; i++) begin
            next_cycle();
            check_value("o_cell_en", 32'(cell_en_out), 32'd0);
        end
        ctrl.cell_sc_en = 1'b0;
        end_test("cell_enable_chain");
    endtask

    // ------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------
    initial begin
        int c;
        int stalls;
        i_rstn        = 1'b0;
        ctrl          = '0;
        a_in          = '0;
        b_in          = '0;
        c_in          = '0;
        cswitch       = '0;
        cell_en       = 1'b0;
        thres         = '0;
        errors        = 0;
        checks        = 0;
        tests_run     = 0;
        tests_bad     = 0;
        test_err_base = 0;
        rng_state     = 32'hb9025138;
        $readmemh("tests/sa_vectors.txt", vec_mem);

        repeat (RST_CYC) @(posedge i_clk);
        #DRV_DLY;
        i_rstn = 1'b1;
        for (c = 0; c < sa_pkg::COLS; c++) begin
            check_value($sformatf("o_c[%0d]", c), 32'(c_out[c]), 32'd0);
        end
        check_value("o_cell_en", 32'(cell_en_out), 32'd0);
        end_test("reset");

        check_cell_chain();
        run_dot_test("dot_product", 0);
        run_dot_test("threshold", 1);
        run_dot_test("stall", 2);

        // Sums parked in the scan registers, then wiped by reg_clear
        check_vectors(0);
        clear_and_enable();
        stream_record(0, stalls);
        for (c = 0; c < sa_pkg::COLS; c++) begin
            check_value($sformatf("o_c[%0d] row 1", c), 32'(c_out[c]), 32'(exp_of(0, 1, c)));
        end
        ctrl.reg_clear = 1'b1;
        next_cycle();
        ctrl.reg_clear = 1'b0;
        check_value("o_cell_en", 32'(cell_en_out), 32'd0);
        scan_and_check(0, 1'b1);
        end_test("clear");

        $display("Tests run %0d, tests with mismatches %0d, checks %0d, errors %0d",
                 tests_run, tests_bad, checks, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

//--- tests/sa_vectors.txt
// Per test: threshold and stall flag, then activation rows 0 and 1 (k = 0..3),
// weight columns 0 and 1 (k = 0..3), expected C[0][0] C[0][1] C[1][0] C[1][1]
// Operands are 8-bit two's complement, results 24-bit two's complement

// Test 0 dot product at threshold 0
0 0
03 FE 05 01
80 04 00 02
7F 06 FD 01
FF 01 04 F8
000163 000007 FFC09A 000074

// Test 1 same streams at threshold 2, values 0 to 3 are negligible
2 0
03 FE 05 01
80 04 00 02
7F 06 FD 01
FF 01 04 F8
FFFFE5 000014 FFC098 000080

// Test 2 same as test 0 with random stall cycles
0 1
03 FE 05 01
80 04 00 02
7F 06 FD 01
FF 01 04 F8
000163 000007 FFC09A 000074

//--- tb.f
source/sa_pkg.sv
source/sa_stage_reg.sv
source/sa_operand_gate.sv
source/sa_multiplier.sv
source/sa_accumulator.sv
source/sa_pe.sv
source/sa_array.sv
tests/sa_tb.sv

//--- Makefile
# Verilator build and run of the systolic array testbench
SIM      := verilator
FLAGS    := --binary --timing
TOP      := sa_tb
FILELIST := tb.f
OBJ_DIR  := obj_dir
PASS_MSG := Regression passed

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

# Status comes from the search for the pass line
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
